// File: sim.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/pi1_if.sv
hdl/reset_seq.sv
hdl/pi1_router.sv
hdl/devtbl.sv
hdl/gpio.sv
hdl/intctrl.sv
hdl/soc_top.sv
verification/soc_tb.sv

// File: Makefile
# Verilator build and run of the SoC glue testbench

VERILATOR ?= verilator
TOP ?= soc_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: simulate clean

# The run fails unless the pass line shows up in the simulator output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: verification/soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module soc_tb import soc_pkg::*; ();

	// Tests take about 350 cycles so this limit leaves a wide margin
	localparam int MAX_CYCLES = 5000;
	localparam int SLOT_LSB = `SOC_SLOT_WORDS_LOG2;

	logic clk_2x_w;
	logic rst_p;
	pi1_op_t pi1_op_i;
	waddr_t pi1_addr_i;
	word_t pi1_data_i;
	sel_t pi1_sel_i;
	word_t pi1_data_o;
	logic [`SOC_GPIO_COUNT-1:0] gp0_i;
	logic [`SOC_GPIO_COUNT-1:0] gp0_o;
	logic [`SOC_INTSRC_COUNT-2:0] irq_i;
	logic intrqst_o;
	logic intrdy_i;
	logic sys_rst_o;

	int checks = 0;
	int errors = 0;
	int errors_reported = 0;
	int cycles = 0;
	integer seed;
	sel_t sel_list [4] = '{4'b0001, 4'b0010, 4'b1100, 4'b0011};

	soc_top soc_top_i (
		.clk_2x_w (clk_2x_w),
		.rst_p (rst_p),
		.pi1_op_i (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.gp0_i (gp0_i),
		.gp0_o (gp0_o),
		.irq_i (irq_i),
		.intrqst_o (intrqst_o),
		.intrdy_i (intrdy_i),
		.sys_rst_o (sys_rst_o)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #2 clk_2x_w = ~clk_2x_w;
	end

	always @(posedge clk_2x_w) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic waddr_t slot_addr(input int slot, input int offset);
		return waddr_t'((slot << SLOT_LSB) | offset);
	endfunction

	function automatic word_t expected_id(input int slot);
		case (slot)
			0: return `SOC_ID_DEVTBL;
			1: return `SOC_ID_GPIO;
			2: return `SOC_ID_INTCTRL;
			default: return `SOC_ID_INVALID;
		endcase
	endfunction

	// Only the two low byte lanes exist in the GPIO output register
	function automatic logic [`SOC_GPIO_COUNT-1:0] byte_merge(
		input logic [`SOC_GPIO_COUNT-1:0] old_value,
		input word_t new_value,
		input sel_t sel
	);
		logic [`SOC_GPIO_COUNT-1:0] merged;
		merged = old_value;
		for (int b = 0; b < `SOC_GPIO_COUNT / 8; b++) begin
			if (sel[b]) begin
				merged[b*8 +: 8] = new_value[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	task automatic expect_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("error at %0d ns: %s", $time, what);
		end
	endtask

	task automatic report_test(input string name);
		if (errors == errors_reported) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_reported);
		end
		errors_reported = errors;
	endtask

	// The operation is accepted one edge after it is driven and read data is sampled mid-cycle
	task automatic bus_access(input pi1_op_t op, input waddr_t addr, input word_t wdata,
			input sel_t sel, output word_t rdata);
		@(posedge clk_2x_w);
		pi1_op_i <= op;
		pi1_addr_i <= addr;
		pi1_data_i <= wdata;
		pi1_sel_i <= sel;
		@(posedge clk_2x_w);
		pi1_op_i <= PI1_NOP;
		@(negedge clk_2x_w);
		rdata = pi1_data_o;
	endtask

	task automatic bus_write(input waddr_t addr, input word_t wdata, input sel_t sel);
		word_t discard;
		bus_access(PI1_WR, addr, wdata, sel, discard);
	endtask

	task automatic read_expect(input string name, input waddr_t addr, input word_t exp);
		word_t rdata;
		bus_access(PI1_RD, addr, '0, '1, rdata);
		expect_value(name, rdata, exp);
	endtask

	task automatic wait_sys_rst(input logic level, input int limit);
		int n;
		n = 0;
		while (sys_rst_o !== level && n < limit) begin
			@(negedge clk_2x_w);
			n++;
		end
	endtask

	task automatic wait_intrqst(input int limit);
		int n;
		n = 0;
		while (intrqst_o !== 1'b1 && n < limit) begin
			@(negedge clk_2x_w);
			n++;
		end
		expect_true(intrqst_o, "intrqst_o did not rise for an enabled pending source");
	endtask

	// The request is gone once the controller reaches its ack state
	task automatic ack_interrupt();
		@(posedge clk_2x_w);
		intrdy_i <= 1'b1;
		@(posedge clk_2x_w);
		intrdy_i <= 1'b0;
		@(negedge clk_2x_w);
		expect_value("intrqst_o", word_t'(intrqst_o), 0);
	endtask

	initial begin
		word_t rdata;
		word_t wdata;
		logic [`SOC_GPIO_COUNT-1:0] expected_gp;
		logic [`SOC_GPIO_COUNT-1:0] gp_in;
		logic held;

		rst_p <= 1'b1;
		pi1_op_i <= PI1_NOP;
		pi1_addr_i <= '0;
		pi1_data_i <= '0;
		pi1_sel_i <= '0;
		gp0_i <= '0;
		irq_i <= '0;
		intrdy_i <= 1'b0;
		seed = 32'h5726cd92;

		// Board reset for 4 cycles, then the hold counter runs down from 31
		for (int k = 0; k < 4; k++) begin
			@(posedge clk_2x_w);
			if (k == 3) begin
				rst_p <= 1'b0;
			end
			@(negedge clk_2x_w);
			expect_value("sys_rst_o", word_t'(sys_rst_o), 1);
		end
		for (int k = 1; k <= 32; k++) begin
			@(negedge clk_2x_w);
			if (k <= 30) begin
				expect_value($sformatf("sys_rst_o after edge %0d", k), word_t'(sys_rst_o), 1);
			end else if (k == 32) begin
				expect_value("sys_rst_o after edge 32", word_t'(sys_rst_o), 0);
			end
		end
		expect_value("gp0_o", word_t'(gp0_o), 0);
		expect_value("intrqst_o", word_t'(intrqst_o), 0);
		report_test("reset sequencing");

		read_expect("devtbl slot count", slot_addr(0, 0), `SOC_SLOT_COUNT);
		for (int k = 0; k < 4; k++) begin
			read_expect($sformatf("slot %0d id", k), slot_addr(0, 2 + 2 * k), expected_id(k));
			read_expect($sformatf("slot %0d size", k), slot_addr(0, 3 + 2 * k),
				`SOC_SLOT_BYTES);
		end
		read_expect("invalid slot data", slot_addr(3, 5), 0);
		// Same offset as the count register but with an upper address bit set
		read_expect("upper address data", slot_addr(4, 0), 0);
		report_test("device table");

		expected_gp = '0;
		for (int k = 0; k < 4; k++) begin
			wdata = $random(seed);
			expected_gp = byte_merge(expected_gp, wdata, sel_list[k]);
			bus_write(slot_addr(1, 1), wdata, sel_list[k]);
			expect_value("gp0_o", word_t'(gp0_o), word_t'(expected_gp));
		end
		read_expect("gpio outputs", slot_addr(1, 1), word_t'(expected_gp));
		wdata = $random(seed);
		bus_access(PI1_RW, slot_addr(1, 1), wdata, 4'hf, rdata);
		expect_value("gpio swap data", rdata, word_t'(expected_gp));
		expect_value("gp0_o", word_t'(gp0_o), word_t'(wdata[`SOC_GPIO_COUNT-1:0]));
		wdata = $random(seed);
		gp_in = wdata[`SOC_GPIO_COUNT-1:0];
		@(posedge clk_2x_w);
		gp0_i <= gp_in;
		@(posedge clk_2x_w);
		read_expect("gpio inputs", slot_addr(1, 0), word_t'(gp_in));
		report_test("gpio");

		// Pending sources with the mask still cleared after reset
		@(posedge clk_2x_w);
		gp0_i <= 16'h5a5a;
		irq_i <= 3'b001;
		repeat (8) begin
			@(negedge clk_2x_w);
			expect_value("intrqst_o", word_t'(intrqst_o), 0);
		end
		bus_write(slot_addr(2, 1), 32'hf, 4'hf);
		wait_intrqst(8);
		read_expect("intctrl mask", slot_addr(2, 1), 32'hf);
		read_expect("intctrl index", slot_addr(2, 0), 0);
		ack_interrupt();
		wait_intrqst(8);
		read_expect("intctrl index", slot_addr(2, 0), 1);
		@(posedge clk_2x_w);
		irq_i <= '0;
		ack_interrupt();
		repeat (4) begin
			@(negedge clk_2x_w);
			expect_value("intrqst_o", word_t'(intrqst_o), 0);
		end
		read_expect("intctrl index", slot_addr(2, 0), 32'hffff_ffff);
		report_test("interrupts");

		// Warm reset clears its own request bit and the peripherals
		bus_write(slot_addr(0, 0), 32'h2, 4'hf);
		wait_sys_rst(1'b1, 4);
		expect_true(sys_rst_o, "sys_rst_o did not rise after a warm reset request");
		wait_sys_rst(1'b0, 32);
		expect_true(!sys_rst_o, "sys_rst_o did not fall within 32 cycles of a warm reset");
		expect_value("gp0_o", word_t'(gp0_o), 0);
		read_expect("gpio outputs", slot_addr(1, 1), 0);
		bus_write(slot_addr(0, 0), 32'h1, 4'hf);
		wait_sys_rst(1'b1, 4);
		expect_true(sys_rst_o, "sys_rst_o did not rise after a power-off request");
		held = 1'b1;
		repeat (100) begin
			@(negedge clk_2x_w);
			held = held & sys_rst_o;
		end
		expect_true(held, "sys_rst_o dropped while the power-off latch should hold it");
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (4) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_sys_rst(1'b0, 32);
		expect_true(!sys_rst_o, "sys_rst_o stayed high after the board reset pulse");
		report_test("software resets");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module soc_top import soc_pkg::*; (
	input logic clk_2x_w,
	input logic rst_p,

	// Bus master port
	input pi1_op_t pi1_op_i,
	input waddr_t pi1_addr_i,
	input word_t pi1_data_i,
	input sel_t pi1_sel_i,
	output word_t pi1_data_o,

	input logic [`SOC_GPIO_COUNT-1:0] gp0_i,
	output logic [`SOC_GPIO_COUNT-1:0] gp0_o,

	// Level requests for interrupt sources 1 to 3
	input logic [`SOC_INTSRC_COUNT-2:0] irq_i,
	output logic intrqst_o,
	input logic intrdy_i,

	output logic sys_rst_o
);

	logic devtbl_rst0;
	logic devtbl_rst1;
	logic gpio_intrqst;
	logic [`SOC_INTSRC_COUNT-1:0] intrdy_src;

	pi1_if devtbl_bus ();
	pi1_if gpio_bus ();
	pi1_if intctrl_bus ();

	reset_seq reset_seq_i (
		.rst_p (rst_p),
		.clk_2x_w (clk_2x_w),
		.rst0_i (devtbl_rst0),
		.rst1_i (devtbl_rst1),
		.sys_rst_o (sys_rst_o)
	);

	pi1_router pi1_router_i (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.op_i (pi1_op_i),
		.addr_i (pi1_addr_i),
		.data_i (pi1_data_i),
		.sel_i (pi1_sel_i),
		.data_o (pi1_data_o),
		.devtbl_bus (devtbl_bus.master),
		.gpio_bus (gpio_bus.master),
		.intctrl_bus (intctrl_bus.master)
	);

	devtbl devtbl_i (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.bus (devtbl_bus.slave),
		.rst0_o (devtbl_rst0),
		.rst1_o (devtbl_rst1)
	);

	// GPIO is interrupt source 0
	gpio gpio_i (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.bus (gpio_bus.slave),
		.gp_i (gp0_i),
		.gp_o (gp0_o),
		.intrqst_o (gpio_intrqst),
		.intrdy_i (intrdy_src[0])
	);

	intctrl intctrl_i (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.bus (intctrl_bus.slave),
		.intrqst_src_i ({irq_i, gpio_intrqst}),
		.intrdy_src_o (intrdy_src),
		.intrqst_o (intrqst_o),
		.intrdy_i (intrdy_i)
	);

endmodule

`default_nettype wire

// File: hdl/intctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module intctrl import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	pi1_if.slave bus,
	input logic [`SOC_INTSRC_COUNT-1:0] intrqst_src_i,
	output logic [`SOC_INTSRC_COUNT-1:0] intrdy_src_o,
	output logic intrqst_o,
	input logic intrdy_i
);

	localparam int SRC_BITSZ = $clog2(`SOC_INTSRC_COUNT);
	localparam logic [`SOC_INTSRC_COUNT-1:0] SRC_ONE = 1;

	intctrl_state_t state_q;
	logic [SRC_BITSZ-1:0] src_q;
	logic [`SOC_INTSRC_COUNT-1:0] enable_q;
	logic [`SOC_INTSRC_COUNT-1:0] pending;
	logic is_rd;
	logic is_wr;
	word_t rd_value;

	// Lowest index wins
	function automatic logic [SRC_BITSZ-1:0] lowest_src(
		input logic [`SOC_INTSRC_COUNT-1:0] pend
	);
		logic [SRC_BITSZ-1:0] idx;
		idx = '0;
		for (int i = `SOC_INTSRC_COUNT - 1; i >= 0; i--) begin
			if (pend[i]) begin
				idx = SRC_BITSZ'(i);
			end
		end
		return idx;
	endfunction

	assign pending = intrqst_src_i & enable_q;
	assign is_rd = (bus.op == PI1_RD) || (bus.op == PI1_RW);
	assign is_wr = (bus.op == PI1_WR) || (bus.op == PI1_RW);

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			state_q <= IC_IDLE;
			src_q <= '0;
		end else begin
			case (state_q)
				IC_IDLE: begin
					if (|pending) begin
						src_q <= lowest_src(pending);
						state_q <= IC_REQUEST;
					end
				end
				// Wait here for the destination as long as it takes
				IC_REQUEST: begin
					if (intrdy_i) begin
						state_q <= IC_ACK;
					end
				end
				default: state_q <= IC_IDLE;
			endcase
		end
	end

	assign intrqst_o = (state_q == IC_REQUEST);
	// One-cycle acknowledge back to the served source
	assign intrdy_src_o = (state_q == IC_ACK) ? (SRC_ONE << src_q) : '0;

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			enable_q <= '0;
		end else if (is_wr && bus.addr == waddr_t'(1) && bus.sel[0]) begin
			enable_q <= bus.data_wr[`SOC_INTSRC_COUNT-1:0];
		end
	end

	always_comb begin
		case (bus.addr)
			waddr_t'(0): rd_value = (state_q == IC_REQUEST) ? word_t'(src_q) : '1;
			waddr_t'(1): rd_value = word_t'(enable_q);
			default: rd_value = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		if (is_rd) begin
			bus.data_rd <= rd_value;
		end
	end

endmodule

`default_nettype wire

// File: hdl/gpio.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module gpio import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	pi1_if.slave bus,
	input logic [`SOC_GPIO_COUNT-1:0] gp_i,
	output logic [`SOC_GPIO_COUNT-1:0] gp_o,
	output logic intrqst_o,
	input logic intrdy_i
);

	localparam int BYTE_COUNT = `SOC_GPIO_COUNT / 8;

	logic [`SOC_GPIO_COUNT-1:0] gp_meta_q;
	logic [`SOC_GPIO_COUNT-1:0] gp_sync_q;
	logic [`SOC_GPIO_COUNT-1:0] gp_seen_q;
	logic is_rd;
	logic is_wr;
	word_t rd_value;

	assign is_rd = (bus.op == PI1_RD) || (bus.op == PI1_RW);
	assign is_wr = (bus.op == PI1_WR) || (bus.op == PI1_RW);

	// Two-flop synchronizer for the pins
	always_ff @(posedge clk_2x_w) begin
		gp_meta_q <= gp_i;
		gp_sync_q <= gp_meta_q;
	end

	// Snapshot taken when the interrupt is acknowledged
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i || intrdy_i) begin
			gp_seen_q <= gp_sync_q;
		end
	end

	assign intrqst_o = (gp_sync_q != gp_seen_q);

	always_comb begin
		case (bus.addr)
			waddr_t'(0): rd_value = word_t'(gp_sync_q);
			waddr_t'(1): rd_value = word_t'(gp_o);
			default: rd_value = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		if (is_rd) begin
			bus.data_rd <= rd_value;
		end
	end

	// Output register, written per byte lane
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			gp_o <= '0;
		end else if (is_wr && bus.addr == waddr_t'(1)) begin
			for (int b = 0; b < BYTE_COUNT; b++) begin
				if (bus.sel[b]) begin
					gp_o[b*8 +: 8] <= bus.data_wr[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/devtbl.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module devtbl import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	pi1_if.slave bus,
	output logic rst0_o,
	output logic rst1_o
);

	localparam int TBL_FIRST = 2;
	localparam int TBL_END = TBL_FIRST + 2 * `SOC_SLOT_COUNT;

	logic is_rd;
	logic is_wr;
	logic in_tbl;
	waddr_t entry;
	word_t rd_value;

	function automatic word_t slot_id(input slot_t slot);
		case (slot)
			SLOT_DEVTBL: return word_t'(`SOC_ID_DEVTBL);
			SLOT_GPIO: return word_t'(`SOC_ID_GPIO);
			SLOT_INTCTRL: return word_t'(`SOC_ID_INTCTRL);
			default: return word_t'(`SOC_ID_INVALID);
		endcase
	endfunction

	assign is_rd = (bus.op == PI1_RD) || (bus.op == PI1_RW);
	assign is_wr = (bus.op == PI1_WR) || (bus.op == PI1_RW);
	assign in_tbl = (bus.addr >= waddr_t'(TBL_FIRST)) && (bus.addr < waddr_t'(TBL_END));
	// Two words per slot: id then map size
	assign entry = (bus.addr - waddr_t'(TBL_FIRST)) >> 1;

	always_comb begin
		rd_value = '0;
		if (bus.addr == '0) begin
			rd_value = word_t'(`SOC_SLOT_COUNT);
		end else if (in_tbl) begin
			rd_value = bus.addr[0] ? word_t'(`SOC_SLOT_BYTES) :
				slot_id(slot_t'(entry[$bits(slot_t)-1:0]));
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (is_rd) begin
			bus.data_rd <= rd_value;
		end
	end

	// Software reset bits; the system reset they cause clears them again
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (is_wr && bus.addr == '0 && bus.sel[0]) begin
			rst0_o <= bus.data_wr[0];
			rst1_o <= bus.data_wr[1];
		end
	end

endmodule

`default_nettype wire

// File: hdl/pi1_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module pi1_router import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input pi1_op_t op_i,
	input waddr_t addr_i,
	input word_t data_i,
	input sel_t sel_i,
	output word_t data_o,
	pi1_if.master devtbl_bus,
	pi1_if.master gpio_bus,
	pi1_if.master intctrl_bus
);

	localparam int SLOT_LSB = `SOC_SLOT_WORDS_LOG2;
	localparam int SLOT_BITSZ = $clog2(`SOC_SLOT_COUNT);
	localparam int UPPER_LSB = SLOT_LSB + SLOT_BITSZ;

	logic upper_nz;
	slot_t req_slot;
	slot_t rd_slot_q;
	waddr_t offset;
	logic is_rd;

	// Anything beyond the four slots falls on the invalid device
	assign upper_nz = |addr_i[`SOC_ADDR_BITSZ-1:UPPER_LSB];
	assign req_slot = upper_nz ? SLOT_INVALID : slot_t'(addr_i[UPPER_LSB-1:SLOT_LSB]);
	assign offset = waddr_t'(addr_i[SLOT_LSB-1:0]);
	assign is_rd = (op_i == PI1_RD) || (op_i == PI1_RW);

	// Only the selected slave sees the operation
	assign devtbl_bus.op = (req_slot == SLOT_DEVTBL) ? op_i : PI1_NOP;
	assign devtbl_bus.addr = offset;
	assign devtbl_bus.data_wr = data_i;
	assign devtbl_bus.sel = sel_i;

	assign gpio_bus.op = (req_slot == SLOT_GPIO) ? op_i : PI1_NOP;
	assign gpio_bus.addr = offset;
	assign gpio_bus.data_wr = data_i;
	assign gpio_bus.sel = sel_i;

	assign intctrl_bus.op = (req_slot == SLOT_INTCTRL) ? op_i : PI1_NOP;
	assign intctrl_bus.addr = offset;
	assign intctrl_bus.data_wr = data_i;
	assign intctrl_bus.sel = sel_i;

	// Remember where the last read went, slave data shows up one cycle later
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rd_slot_q <= SLOT_INVALID;
		end else if (is_rd) begin
			rd_slot_q <= req_slot;
		end
	end

	// Read return mux; the invalid device reads as zero
	always_comb begin
		case (rd_slot_q)
			SLOT_DEVTBL: data_o = devtbl_bus.data_rd;
			SLOT_GPIO: data_o = gpio_bus.data_rd;
			SLOT_INTCTRL: data_o = intctrl_bus.data_rd;
			default: data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/reset_seq.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module reset_seq (
	input logic rst_p,
	input logic clk_2x_w,
	input logic rst0_i,
	input logic rst1_i,
	output logic sys_rst_o
);

	localparam logic [`SOC_RST_CNTR_BITSZ-1:0] CNTR_RELOAD = '1;

	logic [`SOC_RST_CNTR_BITSZ-1:0] cntr_q;
	logic pwroff_q;
	logic warm_rqst;
	logic pwroff_rqst;

	// Cold request (both bits) has no global reset to drive, so it acts as warm
	assign warm_rqst = rst1_i;
	assign pwroff_rqst = rst0_i && !rst1_i;

	// Hold time counter, reloaded by board reset or a warm request
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || warm_rqst) begin
			cntr_q <= CNTR_RELOAD;
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// Power-off latch, only the board reset releases it
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_rqst) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (cntr_q != '0) || pwroff_q;

endmodule

`default_nettype wire

// File: hdl/pi1_if.sv
`timescale 1ns/100ps
`default_nettype none

// Router to slave link, addr carries the word offset within the slot
interface pi1_if;

	soc_pkg::pi1_op_t op;
	soc_pkg::waddr_t addr;
	soc_pkg::word_t data_wr;
	soc_pkg::sel_t sel;
	soc_pkg::word_t data_rd;

	modport master (
		output op,
		output addr,
		output data_wr,
		output sel,
		input data_rd
	);

	modport slave (
		input op,
		input addr,
		input data_wr,
		input sel,
		output data_rd
	);

endinterface

`default_nettype wire

// File: hdl/soc_pkg.sv
`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

	typedef logic [`SOC_DATA_BITSZ-1:0] word_t;
	typedef logic [`SOC_ADDR_BITSZ-1:0] waddr_t;
	typedef logic [`SOC_SEL_BITSZ-1:0] sel_t;

	// PI1_RW swaps: old value comes back, new value is written
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR = 2'b01,
		PI1_RD = 2'b10,
		PI1_RW = 2'b11
	} pi1_op_t;

	typedef enum logic [$clog2(`SOC_SLOT_COUNT)-1:0] {
		SLOT_DEVTBL = 0,
		SLOT_GPIO = 1,
		SLOT_INTCTRL = 2,
		SLOT_INVALID = 3
	} slot_t;

	typedef enum logic [1:0] {
		IC_IDLE,
		IC_REQUEST,
		IC_ACK
	} intctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus geometry
`define SOC_DATA_BITSZ 32
`define SOC_ADDR_BITSZ 30
`define SOC_SEL_BITSZ 4

// Address map, each slot spans 1024 words
`define SOC_SLOT_WORDS_LOG2 10
`define SOC_SLOT_COUNT 4
`define SOC_SLOT_BYTES 4096

// System reset hold time in clk_2x_w cycles, counter reloads to all ones
`define SOC_RST_CNTR_BITSZ 5

// Peripheral sizes
`define SOC_GPIO_COUNT 16
`define SOC_INTSRC_COUNT 4

// Device ids reported by the device table
`define SOC_ID_DEVTBL 7
`define SOC_ID_GPIO 6
`define SOC_ID_INTCTRL 3
`define SOC_ID_INVALID 0

`endif
